//--- common/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define DMEM_WORDS 256
`define RESET_PC   32'h0000_0000

// Primary opcodes
`define OP_SPECIAL 6'h00
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

`define FN_ADDU    6'h21  // SPECIAL function field
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a

`endif

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regf_t;

    typedef enum logic [3:0] {
        OPER_NOP,
        OPER_ADDU,
        OPER_SUBU,
        OPER_AND,
        OPER_OR,
        OPER_XOR,
        OPER_SLT,
        OPER_ADDIU,
        OPER_ORI,
        OPER_LUI,
        OPER_LW,
        OPER_SW,
        OPER_BEQ,
        OPER_BNE
    } oper_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // All zero is a NOP
    typedef struct packed {
        oper_t   oper;
        alu_op_t alu_op;
        regf_t   rs;       // Zero when not read
        regf_t   rt;       // Zero when not read
        regf_t   rd;
        word_t   imm;
        logic    use_imm;
        logic    wr_en;
        logic    load;
        logic    store;
    } decoded_t;

endpackage

`default_nettype wire

//--- common/sram_if.sv
`default_nettype none

interface sram_if
    import mips_pkg::*;
();

    logic  en;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;  // Valid the cycle after a read

    modport master (output en, we, addr, wdata, input rdata);
    modport slave  (input en, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

//--- datapath/alu.sv
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;  // Wraps, no overflow trap
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            ALU_LUI: result = b << 16;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- datapath/decoder.sv
`default_nettype none
`include "mips_config.svh"

module decoder
    import mips_pkg::*;
(
    input  word_t    inst,
    input  addr_t    pc,
    input  word_t    rs_value,
    input  word_t    rt_value,
    output decoded_t dec,
    output logic     branch_taken,
    output addr_t    branch_target
);

    oper_t      oper;
    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      sext;
    word_t      zext;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign sext   = {{16{inst[15]}}, inst[15:0]};
    assign zext   = {16'h0000, inst[15:0]};

    always_comb begin
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_ADDU: oper = OPER_ADDU;
                    `FN_SUBU: oper = OPER_SUBU;
                    `FN_AND:  oper = OPER_AND;
                    `FN_OR:   oper = OPER_OR;
                    `FN_XOR:  oper = OPER_XOR;
                    `FN_SLT:  oper = OPER_SLT;
                    default:  oper = OPER_NOP;
                endcase
            end
            `OP_ADDIU: oper = OPER_ADDIU;
            `OP_ORI:   oper = OPER_ORI;
            `OP_LUI:   oper = OPER_LUI;
            `OP_LW:    oper = OPER_LW;
            `OP_SW:    oper = OPER_SW;
            `OP_BEQ:   oper = OPER_BEQ;
            `OP_BNE:   oper = OPER_BNE;
            default:   oper = OPER_NOP;
        endcase
    end

    always_comb begin
        dec      = '0;
        dec.oper = oper;
        dec.imm  = (oper == OPER_ORI || oper == OPER_LUI) ? zext : sext;
        case (oper)
            OPER_ADDU, OPER_SUBU, OPER_AND, OPER_OR, OPER_XOR, OPER_SLT: begin
                dec.rs    = inst[25:21];
                dec.rt    = inst[20:16];
                dec.rd    = inst[15:11];
                dec.wr_en = 1'b1;
            end
            OPER_ADDIU, OPER_ORI, OPER_LW: begin
                dec.rs      = inst[25:21];
                dec.rd      = inst[20:16];
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
                dec.load    = (oper == OPER_LW);
            end
            OPER_LUI: begin
                dec.rd      = inst[20:16];
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
            end
            OPER_SW: begin
                dec.rs      = inst[25:21];
                dec.rt      = inst[20:16];  // Store data
                dec.use_imm = 1'b1;
                dec.store   = 1'b1;
            end
            OPER_BEQ, OPER_BNE: begin
                dec.rs = inst[25:21];
                dec.rt = inst[20:16];
            end
            default: ;
        endcase
        case (oper)
            OPER_SUBU:          dec.alu_op = ALU_SUB;
            OPER_AND:           dec.alu_op = ALU_AND;
            OPER_OR, OPER_ORI:  dec.alu_op = ALU_OR;
            OPER_XOR:           dec.alu_op = ALU_XOR;
            OPER_SLT:           dec.alu_op = ALU_SLT;
            OPER_LUI:           dec.alu_op = ALU_LUI;
            default:            dec.alu_op = ALU_ADD;  // Also address calc
        endcase
    end

    // Relative to the delay slot
    assign branch_target = pc + 32'd4 + {sext[29:0], 2'b00};
    assign branch_taken  = (oper == OPER_BEQ && rs_value == rt_value) ||
                           (oper == OPER_BNE && rs_value != rt_value);

endmodule

`default_nettype wire

//--- datapath/hazard_unit.sv
`default_nettype none

module hazard_unit
    import mips_pkg::*;
(
    input  decoded_t   id_dec,
    input  decoded_t   ex_dec,
    input  decoded_t   mm_dec,
    input  decoded_t   wb_dec,
    input  logic       imem_stall,
    output logic [1:0] fwd_id_rs,
    output logic [1:0] fwd_id_rt,
    output logic [1:0] fwd_ex_rs,
    output logic [1:0] fwd_ex_rt,
    output logic       pc_stall,
    output logic       if_id_stall,
    output logic       id_ex_flush
);

    logic is_branch;
    logic ex_dep;
    logic mm_dep;
    logic load_use;
    logic branch_wait;
    logic stall;

    // Producer p writes register r
    function automatic logic hit(input decoded_t p, input regf_t r);
        return (r != '0) && p.wr_en && (p.rd == r);
    endfunction

    // Bit 0 takes memory stage, bit 1 writeback; younger first
    function automatic logic [1:0] fwd_sel(input decoded_t mm, input decoded_t wb,
                                           input regf_t r);
        if (hit(mm, r) && !mm.load)
            return 2'b01;
        if (hit(wb, r))
            return 2'b10;
        return 2'b00;
    endfunction

    assign fwd_id_rs = fwd_sel(mm_dec, wb_dec, id_dec.rs);
    assign fwd_id_rt = fwd_sel(mm_dec, wb_dec, id_dec.rt);
    assign fwd_ex_rs = fwd_sel(mm_dec, wb_dec, ex_dec.rs);
    assign fwd_ex_rt = fwd_sel(mm_dec, wb_dec, ex_dec.rt);

    assign is_branch = (id_dec.oper == OPER_BEQ) || (id_dec.oper == OPER_BNE);
    assign ex_dep    = hit(ex_dec, id_dec.rs) || hit(ex_dec, id_dec.rt);
    assign mm_dep    = hit(mm_dec, id_dec.rs) || hit(mm_dec, id_dec.rt);

    // Non-branch consumers pick up a load from writeback in execute
    assign load_use    = ex_dec.load && ex_dep;
    assign branch_wait = is_branch && (ex_dep || (mm_dec.load && mm_dep));

    assign stall       = imem_stall | load_use | branch_wait;
    assign pc_stall    = stall;
    assign if_id_stall = stall;
    assign id_ex_flush = stall;

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`default_nettype none
`include "mips_config.svh"

module datapath
    import mips_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   imem_stall,
    output logic   imem_en,
    output addr_t  imem_addr,
    input  word_t  imem_rdata,
    output regf_t  rs_regf,
    output regf_t  rt_regf,
    input  word_t  rs_data,
    input  word_t  rt_data,
    output logic   rd_we,
    output regf_t  rd_regf,
    output word_t  rd_data,
    sram_if.master dbus,
    output logic   wb_valid,
    output addr_t  wb_pc,
    output regf_t  wb_regf,
    output word_t  wb_data
);

    addr_t      pc;
    logic       fetch_on;
    logic       id_valid;
    addr_t      id_pc;
    word_t      id_inst;
    decoded_t   id_dec;
    word_t      id_rs_value;
    word_t      id_rt_value;
    logic       branch_taken;
    addr_t      branch_target;
    addr_t      ex_pc;
    decoded_t   ex_dec;
    word_t      ex_rs_data;
    word_t      ex_rt_data;
    word_t      ex_rs_value;
    word_t      ex_rt_value;
    word_t      ex_b;
    word_t      ex_result;
    addr_t      mm_pc;
    decoded_t   mm_dec;
    word_t      mm_result;
    word_t      mm_store;
    decoded_t   wb_dec;
    word_t      wb_result;
    word_t      wb_value;
    logic [1:0] fwd_id_rs;
    logic [1:0] fwd_id_rt;
    logic [1:0] fwd_ex_rs;
    logic [1:0] fwd_ex_rt;
    logic       pc_stall;
    logic       if_id_stall;
    logic       id_ex_flush;

    function automatic word_t pick(input logic [1:0] sel, input word_t reg_v,
                                   input word_t mm_v, input word_t wb_v);
        if (sel[0])
            return mm_v;
        if (sel[1])
            return wb_v;
        return reg_v;
    endfunction

    // No fetch while held, so imem_rdata keeps the decode word
    assign imem_en   = fetch_on & ~pc_stall;
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RESET_PC;
            fetch_on <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (imem_en)
                pc <= branch_taken ? branch_target : pc + 32'd4;
            if (!if_id_stall)
                id_valid <= fetch_on;
        end
    end

    always_ff @(posedge clk) begin
        if (!if_id_stall)
            id_pc <= pc;
    end

    assign id_inst     = id_valid ? imem_rdata : '0;
    assign id_rs_value = pick(fwd_id_rs, rs_data, mm_result, wb_value);
    assign id_rt_value = pick(fwd_id_rt, rt_data, mm_result, wb_value);
    assign rs_regf     = id_dec.rs;
    assign rt_regf     = id_dec.rt;

    decoder decoder_inst (
        .inst          (id_inst),
        .pc            (id_pc),
        .rs_value      (id_rs_value),
        .rt_value      (id_rt_value),
        .dec           (id_dec),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // Decoded control, NOP on reset and flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_dec <= '0;
            mm_dec <= '0;
            wb_dec <= '0;
        end else begin
            ex_dec <= id_ex_flush ? '0 : id_dec;
            mm_dec <= ex_dec;
            wb_dec <= mm_dec;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= id_pc;
        ex_rs_data <= id_rs_value;
        ex_rt_data <= id_rt_value;
        mm_pc      <= ex_pc;
        mm_result  <= ex_result;
        mm_store   <= ex_rt_value;
        wb_pc      <= mm_pc;
        wb_result  <= mm_result;
    end

    assign ex_rs_value = pick(fwd_ex_rs, ex_rs_data, mm_result, wb_value);
    assign ex_rt_value = pick(fwd_ex_rt, ex_rt_data, mm_result, wb_value);
    assign ex_b        = ex_dec.use_imm ? ex_dec.imm : ex_rt_value;

    alu alu_inst (
        .op     (ex_dec.alu_op),
        .a      (ex_rs_value),
        .b      (ex_b),
        .result (ex_result)
    );

    assign dbus.en    = mm_dec.load | mm_dec.store;
    assign dbus.we    = mm_dec.store;
    assign dbus.addr  = mm_result;  // Base plus offset from execute
    assign dbus.wdata = mm_store;

    assign wb_value = wb_dec.load ? dbus.rdata : wb_result;
    assign wb_valid = wb_dec.wr_en && (wb_dec.rd != '0);
    assign wb_regf  = wb_dec.rd;
    assign wb_data  = wb_value;
    assign rd_we    = wb_valid;
    assign rd_regf  = wb_dec.rd;
    assign rd_data  = wb_value;

    hazard_unit hazard_unit_inst (
        .id_dec      (id_dec),
        .ex_dec      (ex_dec),
        .mm_dec      (mm_dec),
        .wb_dec      (wb_dec),
        .imem_stall  (imem_stall),
        .fwd_id_rs   (fwd_id_rs),
        .fwd_id_rt   (fwd_id_rt),
        .fwd_ex_rs   (fwd_ex_rs),
        .fwd_ex_rt   (fwd_ex_rt),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .id_ex_flush (id_ex_flush)
    );

    // An access is a load or a store, never both
    assert property (@(posedge clk) disable iff (!arst_n)
        dbus.en |-> (mm_dec.load ^ mm_dec.store))
        else $error("data memory read and written in one cycle");

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none

module regfile
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  regf_t ra,
    input  regf_t rb,
    output word_t da,
    output word_t db,
    input  logic  we,
    input  regf_t wa,
    input  word_t wd
);

    word_t regs [1:31];  // r0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through on a same-cycle hit
    always_comb begin
        da = '0;
        if (ra != '0)
            da = (we && wa == ra) ? wd : regs[ra];
    end

    always_comb begin
        db = '0;
        if (rb != '0)
            db = (we && wa == rb) ? wd : regs[rb];
    end

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`default_nettype none
`include "mips_config.svh"

module data_ram
    import mips_pkg::*;
(
    input logic   clk,
    sram_if.slave bus
);

    localparam int AW = $clog2(`DMEM_WORDS);

    word_t         mem [`DMEM_WORDS];
    logic [AW-1:0] idx;

    assign idx = bus.addr[AW+1:2];  // Drop byte offset

    always_ff @(posedge clk) begin
        if (bus.en) begin
            if (bus.we)
                mem[idx] <= bus.wdata;
            else
                bus.rdata <= mem[idx];
        end
    end

    assert property (@(posedge clk) bus.en |-> (bus.addr[1:0] == 2'b00))
        else $error("unaligned data access at %h", bus.addr);

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
`default_nettype none

module cpu_top
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  imem_stall,
    output logic  imem_en,
    output addr_t imem_addr,
    input  word_t imem_rdata,
    output logic  wb_valid,
    output addr_t wb_pc,
    output regf_t wb_regf,
    output word_t wb_data
);

    regf_t rs_regf;
    regf_t rt_regf;
    word_t rs_data;
    word_t rt_data;
    logic  rd_we;
    regf_t rd_regf;
    word_t rd_data;

    sram_if dbus ();

    datapath datapath_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_stall (imem_stall),
        .imem_en    (imem_en),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .rs_regf    (rs_regf),
        .rt_regf    (rt_regf),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .rd_we      (rd_we),
        .rd_regf    (rd_regf),
        .rd_data    (rd_data),
        .dbus       (dbus),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_regf    (wb_regf),
        .wb_data    (wb_data)
    );

    regfile regfile_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ra     (rs_regf),
        .rb     (rt_regf),
        .da     (rs_data),
        .db     (rt_data),
        .we     (rd_we),
        .wa     (rd_regf),
        .wd     (rd_data)
    );

    data_ram data_ram_inst (
        .clk (clk),
        .bus (dbus)
    );

endmodule

`default_nettype wire

//--- tests/tb_cpu_top.sv
`default_nettype none
`include "mips_config.svh"

module tb_cpu_top
    import mips_pkg::*;
();

    localparam int PROG_LEN  = 64;
    localparam int FINAL_IDX = PROG_LEN - 2;  // BEQ to itself, then a NOP slot
    localparam int TIMEOUT   = 20 + 6 * PROG_LEN;

    logic  clk        = 1'b0;
    logic  arst_n     = 1'b0;
    logic  imem_stall = 1'b0;
    word_t imem_rdata = '0;
    logic  imem_en;
    addr_t imem_addr;
    logic  wb_valid;
    addr_t wb_pc;
    regf_t wb_regf;
    word_t wb_data;

    word_t lfsr = 32'h1b55_c40d;
    word_t prog [PROG_LEN];
    addr_t exp_pc [$];
    regf_t exp_regf [$];
    word_t exp_data [$];
    int    matched    = 0;
    int    checks     = 0;
    int    errors     = 0;
    int    cycles     = 0;
    logic  fetch_seen = 1'b0;

    always #50 clk = ~clk;

    cpu_top cpu_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_stall (imem_stall),
        .imem_en    (imem_en),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_regf    (wb_regf),
        .wb_data    (wb_data)
    );

    // One LFSR step per bit taken
    function automatic word_t next_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input regf_t rs, input regf_t rt,
                                    input regf_t rd);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input regf_t rs, input regf_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Stores only outside any branch shadow, loads only from stored words
    function automatic void build_program();
        int          shadow_end;
        logic        prev_branch;
        logic [15:0] written;
        int          kind;
        int          skip;
        int          w;
        logic [5:0]  fn;
        regf_t       s;
        regf_t       t;
        regf_t       d;
        shadow_end  = 0;
        prev_branch = 1'b0;
        written     = '0;
        for (int i = 0; i < FINAL_IDX; i++) begin
            kind = int'(next_bits(3));
            s    = 5'(next_bits(3));  // r0 now and then
            t    = 5'(next_bits(3));
            d    = 5'(next_bits(3));
            w    = int'(next_bits(4));
            skip = 1 + int'(next_bits(2)) % 3;
            if (kind == 6 && (prev_branch || i + 2 + skip > FINAL_IDX))
                kind = 0;
            if (kind == 5 && i < shadow_end)
                kind = 1;
            if (kind == 4 && !written[w])
                kind = 2;
            prev_branch = 1'b0;
            case (kind)
                0, 1: begin
                    case (int'(next_bits(3)) % 6)
                        0:       fn = `FN_ADDU;
                        1:       fn = `FN_SUBU;
                        2:       fn = `FN_AND;
                        3:       fn = `FN_OR;
                        4:       fn = `FN_XOR;
                        default: fn = `FN_SLT;
                    endcase
                    prog[i] = enc_r(fn, s, t, d);
                end
                2: prog[i] = enc_i(`OP_ADDIU, s, d, 16'(next_bits(16)));
                3: begin
                    if (next_bits(1) == 32'd1)
                        prog[i] = enc_i(`OP_LUI, 5'd0, d, 16'(next_bits(16)));
                    else
                        prog[i] = enc_i(`OP_ORI, s, d, 16'(next_bits(16)));
                end
                4: prog[i] = enc_i(`OP_LW, 5'd0, d, 16'(4 * w));
                5: begin
                    prog[i]    = enc_i(`OP_SW, 5'd0, t, 16'(4 * w));
                    written[w] = 1'b1;
                end
                6: begin
                    if (next_bits(1) == 32'd1)
                        t = s;  // Equal operands, more taken BEQs
                    if (next_bits(1) == 32'd1)
                        prog[i] = enc_i(`OP_BNE, s, t, 16'(skip + 1));
                    else
                        prog[i] = enc_i(`OP_BEQ, s, t, 16'(skip + 1));
                    prev_branch = 1'b1;
                    if (i + 2 + skip > shadow_end)
                        shadow_end = i + 2 + skip;
                end
                default: prog[i] = 32'h0000_0000;
            endcase
        end
        prog[FINAL_IDX]     = enc_i(`OP_BEQ, 5'd0, 5'd0, 16'hffff);
        prog[FINAL_IDX + 1] = 32'h0000_0000;
    endfunction

    // Instruction-level model with one delay slot
    function automatic void model_program();
        word_t      regs [32];
        word_t      mem [16];
        int         pc_i;
        int         npc_i;
        int         tgt;
        int         steps;
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      ea;
        word_t      imm_s;
        logic [5:0] op;
        regf_t      dst;
        logic       wr;
        logic       taken;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        for (int k = 0; k < 16; k++)
            mem[k] = '0;
        pc_i  = 0;
        npc_i = 1;
        steps = 0;
        while (pc_i != FINAL_IDX && steps < 4 * PROG_LEN) begin
            inst  = prog[pc_i];
            op    = inst[31:26];
            a     = regs[inst[25:21]];
            b     = regs[inst[20:16]];
            imm_s = {{16{inst[15]}}, inst[15:0]};
            ea    = a + imm_s;
            dst   = inst[20:16];
            wr    = 1'b0;
            taken = 1'b0;
            res   = '0;
            case (op)
                `OP_SPECIAL: begin
                    dst = inst[15:11];
                    wr  = 1'b1;
                    case (inst[5:0])
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        `FN_XOR:  res = a ^ b;
                        `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  wr = 1'b0;
                    endcase
                end
                `OP_ADDIU: begin
                    res = a + imm_s;
                    wr  = 1'b1;
                end
                `OP_ORI: begin
                    res = a | {16'h0000, inst[15:0]};
                    wr  = 1'b1;
                end
                `OP_LUI: begin
                    res = {inst[15:0], 16'h0000};
                    wr  = 1'b1;
                end
                `OP_LW: begin
                    res = mem[ea[5:2]];
                    wr  = 1'b1;
                end
                `OP_SW:  mem[ea[5:2]] = b;
                `OP_BEQ: taken = (a == b);
                `OP_BNE: taken = (a != b);
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_pc.push_back(addr_t'(pc_i * 4));
                exp_regf.push_back(dst);
                exp_data.push_back(res);
            end
            tgt = npc_i + 1;
            if (taken)
                tgt = pc_i + 1 + int'($signed(inst[15:0]));
            pc_i  = npc_i;
            npc_i = tgt;
            steps++;
        end
    endfunction

    task automatic report_counts();
        $display("Trace %0d of %0d entries matched, %0d checks, %0d errors",
                 matched, exp_pc.size(), checks, errors);
    endtask

    // Instruction memory and random wait
    always @(posedge clk) begin
        if (imem_en && !imem_stall)
            imem_rdata <= prog[imem_addr[7:2]];
        if (arst_n)
            imem_stall <= (next_bits(2) == 32'd0);
    end

    always @(negedge clk) begin
        if (arst_n && imem_en && !fetch_seen) begin
            fetch_seen = 1'b1;
            checks++;
            assert (imem_addr == `RESET_PC) else begin
                errors++;
                $display("ERROR imem_addr: got %h, expected %h", imem_addr, `RESET_PC);
            end
        end
        if (arst_n && wb_valid) begin
            if (matched >= exp_pc.size()) begin
                errors++;
                $display("Extra register write to r%0d after the expected trace ended",
                         wb_regf);
            end else begin
                checks += 3;
                assert (wb_pc == exp_pc[matched]) else begin
                    errors++;
                    $display("ERROR wb_pc: got %h, expected %h", wb_pc, exp_pc[matched]);
                end
                assert (wb_regf == exp_regf[matched]) else begin
                    errors++;
                    $display("ERROR wb_regf: got %h, expected %h",
                             wb_regf, exp_regf[matched]);
                end
                assert (wb_data == exp_data[matched]) else begin
                    errors++;
                    $display("ERROR wb_data: got %h, expected %h",
                             wb_data, exp_data[matched]);
                end
                matched++;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n)
            cycles++;
        if (cycles == TIMEOUT) begin
            $display("Timeout after %0d cycles with the trace incomplete", cycles);
            report_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        build_program();
        model_program();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        checks += 2;
        assert (!imem_en) else begin
            errors++;
            $display("ERROR imem_en: got %h, expected %h", imem_en, 1'b0);
        end
        assert (!wb_valid) else begin
            errors++;
            $display("ERROR wb_valid: got %h, expected %h", wb_valid, 1'b0);
        end
        while (matched < exp_pc.size())
            @(posedge clk);
        repeat (20) @(posedge clk);  // Quiet window for extra writes
        report_counts();
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/mips_pkg.sv
common/sram_if.sv
datapath/alu.sv
datapath/decoder.sv
datapath/hazard_unit.sv
datapath/datapath.sv
hdl/regfile.sv
hdl/data_ram.sv
hdl/cpu_top.sv
tests/tb_cpu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_top -f filelist.f -o sim_cpu

./obj_dir/sim_cpu | tee sim.log

# Pass only if the testbench printed its pass line
grep -qx "=== PASS ===" sim.log
